// ==== source/mci_lite_macros.svh ====
`ifndef MCI_LITE_MACROS_SVH
`define MCI_LITE_MACROS_SVH

// Register port widths
`define MCI_DATA_W 32
`define MCI_ADDR_W 6

// Each aggregated error vector
`define MCI_ERR_W 32

// Watchdog period, two data words
`define MCI_WDT_PERIOD_W 64

// Register word addresses
`define MCI_A_T1_EN          6'd0
`define MCI_A_T1_CTRL        6'd1
`define MCI_A_T1_PERIOD_LO   6'd2
`define MCI_A_T1_PERIOD_HI   6'd3
`define MCI_A_T2_EN          6'd4
`define MCI_A_T2_CTRL        6'd5
`define MCI_A_T2_PERIOD_LO   6'd6
`define MCI_A_T2_PERIOD_HI   6'd7
`define MCI_A_WDT_STATUS     6'd8
`define MCI_A_ERR_FATAL      6'd9
`define MCI_A_ERR_NON_FATAL  6'd10
`define MCI_A_FATAL_MASK     6'd11
`define MCI_A_NON_FATAL_MASK 6'd12
`define MCI_A_INTR_EN        6'd13

`endif

// ==== source/mci_lite_pkg.sv ====
`include "mci_lite_macros.svh"

package mci_lite_pkg;

    // Register access from the host side
    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [`MCI_ADDR_W-1:0] addr;
        logic [`MCI_DATA_W-1:0] wdata;
    } mci_reg_req_t;

    ////////////////////////////////////////
    // Watchdog
    ////////////////////////////////////////

    typedef struct packed {
        logic                         t1_en;
        logic                         t2_en;
        logic                         t1_restart;
        logic                         t2_restart;
        logic [`MCI_WDT_PERIOD_W-1:0] t1_period;
        logic [`MCI_WDT_PERIOD_W-1:0] t2_period;
    } wdt_cfg_t;

    typedef struct packed {
        logic t1_timeout;
        logic t2_timeout;
        logic t1_timeout_p;
        logic t2_timeout_p;
    } wdt_status_t;

    // One-cycle pulses from status writes
    typedef struct packed {
        logic t1_serviced;
        logic t2_serviced;
    } wdt_service_t;

    ////////////////////////////////////////
    // Errors and interrupts
    ////////////////////////////////////////

    typedef struct packed {
        logic [`MCI_ERR_W-1:0] fatal;
        logic [`MCI_ERR_W-1:0] non_fatal;
    } err_status_t;

    typedef struct packed {
        logic [`MCI_ERR_W-1:0] fatal_clr;
        logic [`MCI_ERR_W-1:0] non_fatal_clr;
    } err_clr_t;

    // intr_en bit 0 is timer1 timeout, bit 1 timer2 timeout
    typedef struct packed {
        logic [`MCI_ERR_W-1:0] fatal_mask;
        logic [`MCI_ERR_W-1:0] non_fatal_mask;
        logic [1:0]            intr_en;
    } irq_cfg_t;

endpackage

// ==== source/mci_csr.sv ====
`timescale 1ns/1ns
`include "mci_lite_macros.svh"

module mci_csr (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  mci_lite_pkg::mci_reg_req_t reg_req_i,
    input  mci_lite_pkg::wdt_status_t  wdt_status_i,
    input  mci_lite_pkg::err_status_t  err_status_i,
    output logic [`MCI_DATA_W-1:0]     reg_rdata_o,
    output mci_lite_pkg::wdt_cfg_t     wdt_cfg_o,
    output mci_lite_pkg::wdt_service_t wdt_service_o,
    output mci_lite_pkg::err_clr_t     err_clr_o,
    output mci_lite_pkg::irq_cfg_t     irq_cfg_o
);

    logic                   wr_en;
    logic                   rd_en;
    logic [`MCI_ADDR_W-1:0] addr;
    logic [`MCI_DATA_W-1:0] wdata;
    logic [`MCI_DATA_W-1:0] rdata_nxt;

    assign wr_en = reg_req_i.wr;
    assign rd_en = reg_req_i.rd;
    assign addr  = reg_req_i.addr;
    assign wdata = reg_req_i.wdata;

    ////////////////////////////////////////
    // Write side
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wdt_cfg_o     <= '0;
            wdt_service_o <= '0;
            err_clr_o     <= '0;
            irq_cfg_o     <= '0;
        end else begin
            // Pulses drop back after one cycle
            wdt_cfg_o.t1_restart <= 1'b0;
            wdt_cfg_o.t2_restart <= 1'b0;
            wdt_service_o        <= '0;
            err_clr_o            <= '0;
            if (wr_en) begin
                case (addr)
                    `MCI_A_T1_EN: wdt_cfg_o.t1_en <= wdata[0];
                    `MCI_A_T1_CTRL: wdt_cfg_o.t1_restart <= wdata[0];
                    `MCI_A_T1_PERIOD_LO: begin
                        wdt_cfg_o.t1_period[`MCI_DATA_W-1:0] <= wdata;
                    end
                    `MCI_A_T1_PERIOD_HI: begin
                        wdt_cfg_o.t1_period[`MCI_WDT_PERIOD_W-1:`MCI_DATA_W] <= wdata;
                    end
                    `MCI_A_T2_EN: wdt_cfg_o.t2_en <= wdata[0];
                    `MCI_A_T2_CTRL: wdt_cfg_o.t2_restart <= wdata[0];
                    `MCI_A_T2_PERIOD_LO: begin
                        wdt_cfg_o.t2_period[`MCI_DATA_W-1:0] <= wdata;
                    end
                    `MCI_A_T2_PERIOD_HI: begin
                        wdt_cfg_o.t2_period[`MCI_WDT_PERIOD_W-1:`MCI_DATA_W] <= wdata;
                    end
                    // W1C of the timeout flags services the timers
                    `MCI_A_WDT_STATUS: begin
                        wdt_service_o.t1_serviced <= wdata[0];
                        wdt_service_o.t2_serviced <= wdata[1];
                    end
                    `MCI_A_ERR_FATAL: err_clr_o.fatal_clr <= wdata;
                    `MCI_A_ERR_NON_FATAL: err_clr_o.non_fatal_clr <= wdata;
                    `MCI_A_FATAL_MASK: irq_cfg_o.fatal_mask <= wdata;
                    `MCI_A_NON_FATAL_MASK: irq_cfg_o.non_fatal_mask <= wdata;
                    `MCI_A_INTR_EN: irq_cfg_o.intr_en <= wdata[1:0];
                    default: ;
                endcase
            end
        end
    end

    ////////////////////////////////////////
    // Read side
    ////////////////////////////////////////

    // CTRL and unmapped words fall to zero
    always_comb begin
        rdata_nxt = '0;
        case (addr)
            `MCI_A_T1_EN: rdata_nxt[0] = wdt_cfg_o.t1_en;
            `MCI_A_T1_PERIOD_LO: rdata_nxt = wdt_cfg_o.t1_period[`MCI_DATA_W-1:0];
            `MCI_A_T1_PERIOD_HI: begin
                rdata_nxt = wdt_cfg_o.t1_period[`MCI_WDT_PERIOD_W-1:`MCI_DATA_W];
            end
            `MCI_A_T2_EN: rdata_nxt[0] = wdt_cfg_o.t2_en;
            `MCI_A_T2_PERIOD_LO: rdata_nxt = wdt_cfg_o.t2_period[`MCI_DATA_W-1:0];
            `MCI_A_T2_PERIOD_HI: begin
                rdata_nxt = wdt_cfg_o.t2_period[`MCI_WDT_PERIOD_W-1:`MCI_DATA_W];
            end
            `MCI_A_WDT_STATUS: begin
                rdata_nxt[1:0] = {wdt_status_i.t2_timeout, wdt_status_i.t1_timeout};
            end
            `MCI_A_ERR_FATAL: rdata_nxt = err_status_i.fatal;
            `MCI_A_ERR_NON_FATAL: rdata_nxt = err_status_i.non_fatal;
            `MCI_A_FATAL_MASK: rdata_nxt = irq_cfg_o.fatal_mask;
            `MCI_A_NON_FATAL_MASK: rdata_nxt = irq_cfg_o.non_fatal_mask;
            `MCI_A_INTR_EN: rdata_nxt[1:0] = irq_cfg_o.intr_en;
            default: rdata_nxt = '0;
        endcase
    end

    // Read data holds until the next read
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            reg_rdata_o <= '0;
        end else if (rd_en) begin
            reg_rdata_o <= rdata_nxt;
        end
    end

    // Host never issues a read and a write together
    a_no_wr_rd: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(reg_req_i.wr && reg_req_i.rd));

endmodule

// ==== source/mci_wdt.sv ====
`timescale 1ns/1ns
`include "mci_lite_macros.svh"

module mci_wdt (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  mci_lite_pkg::wdt_cfg_t     wdt_cfg_i,
    input  mci_lite_pkg::wdt_service_t wdt_service_i,
    output mci_lite_pkg::wdt_status_t  wdt_status_o,
    output logic                       nmi_intr_o
);

    logic [`MCI_WDT_PERIOD_W-1:0] t1_cnt;
    logic [`MCI_WDT_PERIOD_W-1:0] t2_cnt;
    logic                         cascade;
    logic                         t1_clr;
    logic                         t1_hit;
    logic                         t2_run;
    logic                         t2_clr;
    logic                         t2_hit;

    // Timer2 disabled with timer1 enabled
    assign cascade = wdt_cfg_i.t1_en & ~wdt_cfg_i.t2_en;

    assign t1_clr = ~wdt_cfg_i.t1_en | wdt_cfg_i.t1_restart | wdt_service_i.t1_serviced;
    assign t1_hit = ~t1_clr & ~wdt_status_o.t1_timeout & (t1_cnt == wdt_cfg_i.t1_period);

    // Own enable, or behind an expired timer1
    assign t2_run = wdt_cfg_i.t2_en | (cascade & wdt_status_o.t1_timeout);
    assign t2_clr = wdt_cfg_i.t2_restart | wdt_service_i.t2_serviced |
                    (cascade ? wdt_service_i.t1_serviced : ~wdt_cfg_i.t2_en);
    assign t2_hit = t2_run & ~t2_clr & ~wdt_status_o.t2_timeout &
                    (t2_cnt == wdt_cfg_i.t2_period);

    ////////////////////////////////////////
    // Counters and flags
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            t1_cnt       <= '0;
            t2_cnt       <= '0;
            wdt_status_o <= '0;
            nmi_intr_o   <= 1'b0;
        end else begin
            // Counter parks at the period once it gets there
            if (t1_clr) begin
                t1_cnt <= '0;
            end else if (!wdt_status_o.t1_timeout && t1_cnt != wdt_cfg_i.t1_period) begin
                t1_cnt <= t1_cnt + 1'b1;
            end

            if (t2_clr) begin
                t2_cnt <= '0;
            end else if (t2_run && !wdt_status_o.t2_timeout &&
                         t2_cnt != wdt_cfg_i.t2_period) begin
                t2_cnt <= t2_cnt + 1'b1;
            end

            if (wdt_service_i.t1_serviced) begin
                wdt_status_o.t1_timeout <= 1'b0;
            end else if (t1_hit) begin
                wdt_status_o.t1_timeout <= 1'b1;
            end

            if (wdt_service_i.t2_serviced) begin
                wdt_status_o.t2_timeout <= 1'b0;
            end else if (t2_hit) begin
                wdt_status_o.t2_timeout <= 1'b1;
            end

            // Pulses line up with the rising flags
            wdt_status_o.t1_timeout_p <= t1_hit;
            wdt_status_o.t2_timeout_p <= t2_hit;

            // Sticky until reset
            if (t2_hit && cascade) begin
                nmi_intr_o <= 1'b1;
            end
        end
    end

    a_t2_waits_t1: assert property (@(posedge clk) disable iff (!rst_n_i)
        (cascade && !wdt_status_o.t1_timeout) |=> (t2_cnt == '0 || t2_cnt == $past(t2_cnt)));

    a_nmi_sticky: assert property (@(posedge clk)
        (nmi_intr_o && rst_n_i) |=> nmi_intr_o);

endmodule

// ==== source/mci_err_agg.sv ====
`timescale 1ns/1ns
`include "mci_lite_macros.svh"

module mci_err_agg (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [`MCI_ERR_W-1:0]     agg_error_fatal_i,
    input  logic [`MCI_ERR_W-1:0]     agg_error_non_fatal_i,
    input  mci_lite_pkg::err_clr_t    err_clr_i,
    output mci_lite_pkg::err_status_t err_status_o
);

    logic [`MCI_ERR_W-1:0] fatal_nxt;
    logic [`MCI_ERR_W-1:0] non_fatal_nxt;

    ////////////////////////////////////////
    // Sticky status
    ////////////////////////////////////////

    // A new error in the clear cycle keeps its bit set
    assign fatal_nxt     = (err_status_o.fatal & ~err_clr_i.fatal_clr) | agg_error_fatal_i;
    assign non_fatal_nxt = (err_status_o.non_fatal & ~err_clr_i.non_fatal_clr) |
                           agg_error_non_fatal_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            err_status_o <= '0;
        end else begin
            err_status_o.fatal     <= fatal_nxt;
            err_status_o.non_fatal <= non_fatal_nxt;
        end
    end

    // Status and clear share bit order, so one vector check covers both
    a_fall_on_clear: assert property (@(posedge clk)
        rst_n_i |=> ((~err_status_o & $past(err_status_o) & ~$past(err_clr_i)) == '0));

endmodule

// ==== source/mci_irq_out.sv ====
`timescale 1ns/1ns

module mci_irq_out (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  mci_lite_pkg::err_status_t err_status_i,
    input  mci_lite_pkg::wdt_status_t wdt_status_i,
    input  mci_lite_pkg::irq_cfg_t    irq_cfg_i,
    output logic                      all_error_fatal_o,
    output logic                      all_error_non_fatal_o,
    output logic                      mci_intr_o
);

    logic       fatal_any;
    logic       non_fatal_any;
    logic [1:0] timeout_vec;

    // Mask bit set hides the error
    assign fatal_any     = |(err_status_i.fatal & ~irq_cfg_i.fatal_mask);
    assign non_fatal_any = |(err_status_i.non_fatal & ~irq_cfg_i.non_fatal_mask);
    assign timeout_vec   = {wdt_status_i.t2_timeout, wdt_status_i.t1_timeout};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            all_error_fatal_o     <= 1'b0;
            all_error_non_fatal_o <= 1'b0;
            mci_intr_o            <= 1'b0;
        end else begin
            all_error_fatal_o     <= fatal_any;
            all_error_non_fatal_o <= non_fatal_any;
            mci_intr_o            <= |(timeout_vec & irq_cfg_i.intr_en);
        end
    end

    // Enabled timeout pulse from the watchdog reaches the interrupt next cycle
    a_timeout_intr: assert property (@(posedge clk) disable iff (!rst_n_i)
        ((wdt_status_i.t1_timeout_p && irq_cfg_i.intr_en[0]) ||
         (wdt_status_i.t2_timeout_p && irq_cfg_i.intr_en[1])) |=> mci_intr_o);

endmodule

// ==== source/mci_lite_top.sv ====
`timescale 1ns/1ns
`include "mci_lite_macros.svh"

module mci_lite_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  mci_lite_pkg::mci_reg_req_t reg_req_i,
    output logic [`MCI_DATA_W-1:0]     reg_rdata_o,
    input  logic [`MCI_ERR_W-1:0]      agg_error_fatal_i,
    input  logic [`MCI_ERR_W-1:0]      agg_error_non_fatal_i,
    output logic                       all_error_fatal_o,
    output logic                       all_error_non_fatal_o,
    output logic                       mci_intr_o,
    output logic                       nmi_intr_o
);

    mci_lite_pkg::wdt_cfg_t     wdt_cfg;
    mci_lite_pkg::wdt_service_t wdt_service;
    mci_lite_pkg::wdt_status_t  wdt_status;
    mci_lite_pkg::err_clr_t     err_clr;
    mci_lite_pkg::err_status_t  err_status;
    mci_lite_pkg::irq_cfg_t     irq_cfg;

    // Register bank
    mci_csr i_mci_csr (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .reg_req_i     (reg_req_i),
        .wdt_status_i  (wdt_status),
        .err_status_i  (err_status),
        .reg_rdata_o   (reg_rdata_o),
        .wdt_cfg_o     (wdt_cfg),
        .wdt_service_o (wdt_service),
        .err_clr_o     (err_clr),
        .irq_cfg_o     (irq_cfg)
    );

    // Watchdog, drives the NMI directly
    mci_wdt i_mci_wdt (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .wdt_cfg_i     (wdt_cfg),
        .wdt_service_i (wdt_service),
        .wdt_status_o  (wdt_status),
        .nmi_intr_o    (nmi_intr_o)
    );

    mci_err_agg i_mci_err_agg (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .agg_error_fatal_i     (agg_error_fatal_i),
        .agg_error_non_fatal_i (agg_error_non_fatal_i),
        .err_clr_i             (err_clr),
        .err_status_o          (err_status)
    );

    mci_irq_out i_mci_irq_out (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .err_status_i          (err_status),
        .wdt_status_i          (wdt_status),
        .irq_cfg_i             (irq_cfg),
        .all_error_fatal_o     (all_error_fatal_o),
        .all_error_non_fatal_o (all_error_non_fatal_o),
        .mci_intr_o            (mci_intr_o)
    );

endmodule

// ==== dv/mci_lite_tb.sv ====
`timescale 1ns/1ns
`include "mci_lite_macros.svh"

module mci_lite_tb;

    // Watchdog periods for the independent and cascade tests
    localparam int T1_P = 20;
    localparam int T2_P = 40;
    localparam int C1_P = 12;
    localparam int C2_P = 16;
    // Rough length of each test in cycles, initial reset first
    localparam int TEST_CYCLES = 10 + 60 + 80 + 60 + 60 + (T1_P + 40) + (C1_P + C2_P + 40);
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    localparam logic [5:0] RW_ADDRS [9] = '{`MCI_A_T1_PERIOD_LO, `MCI_A_T1_PERIOD_HI,
        `MCI_A_T2_PERIOD_LO, `MCI_A_T2_PERIOD_HI, `MCI_A_T1_EN, `MCI_A_T2_EN,
        `MCI_A_FATAL_MASK, `MCI_A_NON_FATAL_MASK, `MCI_A_INTR_EN};

    // Shadow of the registers and sticky status
    typedef struct packed {
        logic        t1_en;
        logic        t2_en;
        logic [63:0] t1_period;
        logic [63:0] t2_period;
        logic [1:0]  wdt_status;
        logic [31:0] fatal;
        logic [31:0] non_fatal;
        logic [31:0] fatal_mask;
        logic [31:0] non_fatal_mask;
        logic [1:0]  intr_en;
    } shadow_t;

    logic                       clk;
    logic                       rst_n_i;
    mci_lite_pkg::mci_reg_req_t reg_req;
    logic [`MCI_DATA_W-1:0]     reg_rdata;
    logic [`MCI_ERR_W-1:0]      err_fatal;
    logic [`MCI_ERR_W-1:0]      err_non_fatal;
    logic                       all_fatal;
    logic                       all_non_fatal;
    logic                       mci_intr;
    logic                       nmi_intr;

    shadow_t     model;
    logic [15:0] lfsr_state;
    logic [31:0] exp_rdata;
    logic        exp_valid;
    logic        cmp_pending = 1'b0;
    logic [31:0] cmp_exp;
    logic [5:0]  cmp_addr;
    int          cycles = 0;
    int          errors = 0;
    int          test_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    mci_lite_top i_mci_lite_top (
        .clk                   (clk),
        .rst_n_i               (rst_n_i),
        .reg_req_i             (reg_req),
        .reg_rdata_o           (reg_rdata),
        .agg_error_fatal_i     (err_fatal),
        .agg_error_non_fatal_i (err_non_fatal),
        .all_error_fatal_o     (all_fatal),
        .all_error_non_fatal_o (all_non_fatal),
        .mci_intr_o            (mci_intr),
        .nmi_intr_o            (nmi_intr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Reference model and checking
    ////////////////////////////////////////

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    function automatic logic [31:0] reference_read(logic [5:0] addr, shadow_t m);
        case (addr)
            `MCI_A_T1_EN:          return {31'd0, m.t1_en};
            `MCI_A_T1_PERIOD_LO:   return m.t1_period[31:0];
            `MCI_A_T1_PERIOD_HI:   return m.t1_period[63:32];
            `MCI_A_T2_EN:          return {31'd0, m.t2_en};
            `MCI_A_T2_PERIOD_LO:   return m.t2_period[31:0];
            `MCI_A_T2_PERIOD_HI:   return m.t2_period[63:32];
            `MCI_A_WDT_STATUS:     return {30'd0, m.wdt_status};
            `MCI_A_ERR_FATAL:      return m.fatal;
            `MCI_A_ERR_NON_FATAL:  return m.non_fatal;
            `MCI_A_FATAL_MASK:     return m.fatal_mask;
            `MCI_A_NON_FATAL_MASK: return m.non_fatal_mask;
            `MCI_A_INTR_EN:        return {30'd0, m.intr_en};
            default:               return '0;
        endcase
    endfunction

    function void update_model(logic [5:0] addr, logic [31:0] data);
        case (addr)
            `MCI_A_T1_EN:          model.t1_en = data[0];
            `MCI_A_T1_PERIOD_LO:   model.t1_period[31:0] = data;
            `MCI_A_T1_PERIOD_HI:   model.t1_period[63:32] = data;
            `MCI_A_T2_EN:          model.t2_en = data[0];
            `MCI_A_T2_PERIOD_LO:   model.t2_period[31:0] = data;
            `MCI_A_T2_PERIOD_HI:   model.t2_period[63:32] = data;
            `MCI_A_WDT_STATUS:     model.wdt_status = model.wdt_status & ~data[1:0];
            `MCI_A_ERR_FATAL:      model.fatal = model.fatal & ~data;
            `MCI_A_ERR_NON_FATAL:  model.non_fatal = model.non_fatal & ~data;
            `MCI_A_FATAL_MASK:     model.fatal_mask = data;
            `MCI_A_NON_FATAL_MASK: model.non_fatal_mask = data;
            `MCI_A_INTR_EN:        model.intr_en = data[1:0];
            default: ;
        endcase
    endfunction

    task check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task report_failure(string what);
        $display("%s", what);
        errors++;
    endtask

    // Read data settles on the edge after the strobe
    always @(posedge clk) begin
        cmp_pending <= reg_req.rd && exp_valid;
        cmp_exp     <= exp_rdata;
        cmp_addr    <= reg_req.addr;
    end

    always @(negedge clk) begin
        if (cmp_pending) begin
            check_value($sformatf("reg_rdata_o[0x%02h]", cmp_addr), reg_rdata, cmp_exp);
        end
    end

    task check_error_outputs();
        check_value("all_error_fatal_o", 32'(all_fatal),
                    32'(|(model.fatal & ~model.fatal_mask)));
        check_value("all_error_non_fatal_o", 32'(all_non_fatal),
                    32'(|(model.non_fatal & ~model.non_fatal_mask)));
    endtask

    ////////////////////////////////////////
    // Bus and pin drivers
    ////////////////////////////////////////

    task idle(int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    task apply_reset();
        rst_n_i = 1'b0;
        model = '0;
        repeat (10) @(posedge clk);
        #2;
        rst_n_i = 1'b1;
    endtask

    task write_reg(logic [5:0] addr, logic [31:0] data);
        reg_req.wr    = 1'b1;
        reg_req.addr  = addr;
        reg_req.wdata = data;
        update_model(addr, data);
        idle(1);
        reg_req.wr = 1'b0;
    endtask

    task read_check(logic [5:0] addr);
        reg_req.rd   = 1'b1;
        reg_req.addr = addr;
        exp_rdata    = reference_read(addr, model);
        exp_valid    = 1'b1;
        idle(1);
        reg_req.rd = 1'b0;
        exp_valid  = 1'b0;
    endtask

    task pulse_errors(logic [31:0] f, logic [31:0] nf);
        err_fatal       = f;
        err_non_fatal   = nf;
        model.fatal     = model.fatal | f;
        model.non_fatal = model.non_fatal | nf;
        idle(1);
        err_fatal     = '0;
        err_non_fatal = '0;
    endtask

    // Holds a status read every cycle, counted from the restart write
    task automatic wait_status(int bit_idx, int lo, int hi);
        int   n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        reg_req.rd   = 1'b1;
        reg_req.addr = `MCI_A_WDT_STATUS;
        while (!seen && n < hi + 5) begin
            idle(1);
            n++;
            seen = reg_rdata[bit_idx];
        end
        reg_req.rd = 1'b0;
        // Read data trails the flag by one cycle
        n--;
        if (!seen) begin
            report_failure($sformatf("Timer%0d timeout never showed in status", bit_idx + 1));
        end else if (n < lo || n > hi) begin
            report_failure($sformatf("Timer%0d timeout after %0d cycles, allowed %0d to %0d",
                                     bit_idx + 1, n, lo, hi));
        end
    endtask

    task automatic wait_nmi(int lo, int hi);
        int n;
        n = 0;
        while (!nmi_intr && n < hi + 5) begin
            idle(1);
            n++;
        end
        if (!nmi_intr) begin
            report_failure("NMI never rose in cascade mode");
        end else if (n < lo || n > hi) begin
            report_failure($sformatf("NMI rose after %0d cycles, allowed %0d to %0d", n, lo, hi));
        end
    endtask

    task end_test(string name);
        idle(1);
        tests_run++;
        if (errors != test_start) begin
            tests_failed++;
            $display("test %-12s FAIL, %0d errors", name, errors - test_start);
        end else begin
            $display("test %-12s ok", name);
        end
        test_start = errors;
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task test_reset();
        for (int a = 0; a < 16; a++) begin
            read_check(6'(a));
        end
        check_error_outputs();
        check_value("mci_intr_o", 32'(mci_intr), 32'd0);
        check_value("nmi_intr_o", 32'(nmi_intr), 32'd0);
        end_test("reset");
    endtask

    task test_registers();
        // Periods go in before the enables so no timer can expire
        foreach (RW_ADDRS[i]) begin
            write_reg(RW_ADDRS[i], random_word());
        end
        write_reg(`MCI_A_T1_CTRL, random_word());
        write_reg(`MCI_A_T2_CTRL, random_word());
        write_reg(6'(14 + random_word() % 50), random_word());
        for (int a = 0; a < 16; a++) begin
            read_check(6'(a));
        end
        for (int i = 0; i < 3; i++) begin
            read_check(6'(14 + random_word() % 50));
        end
        write_reg(`MCI_A_T1_EN, 32'd0);
        write_reg(`MCI_A_T2_EN, 32'd0);
        end_test("registers");
    endtask

    task automatic test_errors();
        logic [31:0] f;
        logic [31:0] nf;
        write_reg(`MCI_A_FATAL_MASK, 32'd0);
        write_reg(`MCI_A_NON_FATAL_MASK, 32'd0);
        for (int i = 0; i < 4; i++) begin
            pulse_errors(random_word(), random_word());
        end
        idle(1);
        check_error_outputs();
        read_check(`MCI_A_ERR_FATAL);
        read_check(`MCI_A_ERR_NON_FATAL);
        f  = model.fatal;
        nf = model.non_fatal;
        write_reg(`MCI_A_ERR_FATAL, f);
        write_reg(`MCI_A_ERR_NON_FATAL, nf);
        idle(2);
        read_check(`MCI_A_ERR_FATAL);
        read_check(`MCI_A_ERR_NON_FATAL);
        check_error_outputs();
        end_test("errors");
    endtask

    task automatic test_masking();
        logic [31:0] f;
        logic [31:0] nf;
        int          fb;
        int          nb;
        write_reg(`MCI_A_FATAL_MASK, '1);
        write_reg(`MCI_A_NON_FATAL_MASK, '1);
        f  = random_word() | 32'h0000_0010;
        nf = random_word() | 32'h0000_0100;
        pulse_errors(f, nf);
        idle(1);
        check_error_outputs();
        read_check(`MCI_A_ERR_FATAL);
        read_check(`MCI_A_ERR_NON_FATAL);
        fb = 0;
        nb = 0;
        while (!model.fatal[fb]) fb++;
        while (!model.non_fatal[nb]) nb++;
        write_reg(`MCI_A_FATAL_MASK, ~(32'd1 << fb));
        idle(1);
        check_error_outputs();
        write_reg(`MCI_A_NON_FATAL_MASK, ~(32'd1 << nb));
        idle(1);
        check_error_outputs();
        f  = model.fatal;
        nf = model.non_fatal;
        write_reg(`MCI_A_ERR_FATAL, f);
        write_reg(`MCI_A_ERR_NON_FATAL, nf);
        idle(2);
        check_error_outputs();
        end_test("masking");
    endtask

    task test_wdt_independent();
        write_reg(`MCI_A_T1_PERIOD_LO, T1_P);
        write_reg(`MCI_A_T1_PERIOD_HI, 32'd0);
        write_reg(`MCI_A_T2_PERIOD_LO, T2_P);
        write_reg(`MCI_A_T2_PERIOD_HI, 32'd0);
        write_reg(`MCI_A_INTR_EN, 32'd1);
        write_reg(`MCI_A_T2_EN, 32'd1);
        write_reg(`MCI_A_T1_EN, 32'd1);
        write_reg(`MCI_A_T1_CTRL, 32'd1);
        wait_status(0, T1_P + 1, T1_P + 3);
        model.wdt_status[0] = 1'b1;
        idle(1);
        check_value("mci_intr_o", 32'(mci_intr), 32'd1);
        read_check(`MCI_A_WDT_STATUS);
        write_reg(`MCI_A_T1_EN, 32'd0);
        write_reg(`MCI_A_T2_EN, 32'd0);
        write_reg(`MCI_A_WDT_STATUS, 32'd3);
        idle(2);
        read_check(`MCI_A_WDT_STATUS);
        check_value("mci_intr_o", 32'(mci_intr), 32'd0);
        check_value("nmi_intr_o", 32'(nmi_intr), 32'd0);
        end_test("wdt_indep");
    endtask

    task test_wdt_cascade();
        write_reg(`MCI_A_T1_PERIOD_LO, C1_P);
        write_reg(`MCI_A_T2_PERIOD_LO, C2_P);
        write_reg(`MCI_A_T1_EN, 32'd1);
        write_reg(`MCI_A_T1_CTRL, 32'd1);
        wait_nmi(C1_P + C2_P + 2, C1_P + C2_P + 6);
        model.wdt_status = 2'b11;
        read_check(`MCI_A_WDT_STATUS);
        write_reg(`MCI_A_WDT_STATUS, 32'd3);
        idle(1);
        read_check(`MCI_A_WDT_STATUS);
        idle(2);
        check_value("nmi_intr_o", 32'(nmi_intr), 32'd1);
        apply_reset();
        idle(1);
        check_value("nmi_intr_o", 32'(nmi_intr), 32'd0);
        read_check(`MCI_A_WDT_STATUS);
        end_test("wdt_cascade");
    endtask

    initial begin
        rst_n_i       = 1'b0;
        reg_req       = '0;
        err_fatal     = '0;
        err_non_fatal = '0;
        exp_rdata     = '0;
        exp_valid     = 1'b0;
        lfsr_state    = 16'd57;
        apply_reset();
        test_reset();
        test_registers();
        test_errors();
        test_masking();
        test_wdt_independent();
        test_wdt_cascade();
        $display("tests %0d, failed %0d, errors %0d, cycles %0d",
                 tests_run, tests_failed, errors, cycles);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+source
source/mci_lite_pkg.sv
source/mci_csr.sv
source/mci_wdt.sv
source/mci_err_agg.sv
source/mci_irq_out.sv
source/mci_lite_top.sv
dv/mci_lite_tb.sv

// ==== Makefile ====
# Verilator build and run for the MCI lite testbench

VERILATOR ?= verilator
TOP       ?= mci_lite_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= ./obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
PASS_MSG  ?= Testbench passed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up as a line of its own
run: compile
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
